//--- common/cpu_consts.svh
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

// datapath and address width
`define WORD_W      32

// architectural register file
`define REG_NUM     32
`define REG_IDX_W   5

// first fetch address after reset
`define RESET_PC    32'hbfc0_0000

// golden trace byte write enable
`define TRACE_WEN_W 4

`endif

//--- common/isa_pkg.sv
`default_nettype none

`include "cpu_consts.svh"

package isa_pkg;

    typedef logic [`WORD_W-1:0]    word_t;
    typedef logic [`REG_IDX_W-1:0] reg_idx_t;
    typedef logic [4:0]            shamt_t;
    typedef logic [15:0]           imm16_t;

    // primary opcode, instr[31:26]
    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00,
        OP_ADDIU   = 6'h09,
        OP_ANDI    = 6'h0c,
        OP_ORI     = 6'h0d,
        OP_XORI    = 6'h0e,
        OP_LUI     = 6'h0f
    } opcode_t;

    // function field of SPECIAL, instr[5:0]
    typedef enum logic [5:0] {
        FN_SLL  = 6'h00,
        FN_SRL  = 6'h02,
        FN_ADDU = 6'h21,
        FN_SUBU = 6'h23,
        FN_AND  = 6'h24,
        FN_OR   = 6'h25,
        FN_XOR  = 6'h26,
        FN_SLT  = 6'h2a
    } funct_t;

endpackage

`default_nettype wire

//--- common/pipe_pkg.sv
`default_nettype none

package pipe_pkg;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLL,
        ALU_SRL,
        ALU_LUI
    } alu_op_t;

    // IF/ID latch
    typedef struct packed {
        logic             valid;
        isa_pkg::word_t   pc;
        isa_pkg::word_t   instr;
    } if_id_t;

    // ID/EX latch, operands already resolved
    typedef struct packed {
        logic             valid;
        isa_pkg::word_t   pc;
        alu_op_t          alu_op;
        isa_pkg::word_t   a;
        isa_pkg::word_t   b;     // rt, immediate or shift amount
        isa_pkg::reg_idx_t dst;
        logic             reg_wr;
    } id_ex_t;

    // EX/WB latch, also used for bypass and the rf write port
    typedef struct packed {
        logic             valid;
        isa_pkg::word_t   pc;
        isa_pkg::word_t   result;
        isa_pkg::reg_idx_t dst;
        logic             reg_wr;
    } ex_wb_t;

endpackage

`default_nettype wire

//--- hdl/fetch_stage.sv
`default_nettype none

`include "cpu_consts.svh"

module fetch_stage (
    input  logic             aclk,
    input  logic             rst,
    input  logic             instr_valid,
    input  isa_pkg::word_t   instr,
    output pipe_pkg::if_id_t if_id
);

    isa_pkg::word_t pc;     // address of next accepted instruction

    always_ff @(posedge aclk) begin
        // payload only moves on an accepted instruction
        if (instr_valid) begin
            if_id.pc    <= pc;
            if_id.instr <= instr;
        end

        if (rst) begin
            if_id.valid <= 1'b0;
            pc          <= `RESET_PC;
        end else begin
            if_id.valid <= instr_valid;   // low means bubble
            if (instr_valid) begin
                pc <= pc + isa_pkg::word_t'(4);
            end
        end
    end

endmodule

`default_nettype wire

//--- decode/reg_file.sv
`default_nettype none

`include "cpu_consts.svh"

module reg_file (
    input  logic              aclk,
    input  logic              rst,
    input  isa_pkg::reg_idx_t raddr_a,
    input  isa_pkg::reg_idx_t raddr_b,
    output isa_pkg::word_t    rdata_a,
    output isa_pkg::word_t    rdata_b,
    input  logic              we,
    input  isa_pkg::reg_idx_t waddr,
    input  isa_pkg::word_t    wdata
);

    isa_pkg::word_t regs [`REG_NUM];

    always_ff @(posedge aclk) begin
        if (rst) begin
            for (int i = 0; i < `REG_NUM; i++) begin
                regs[i] <= '0;
            end
        end else if (we && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    // async read, r0 hardwired
    assign rdata_a = (raddr_a == '0) ? '0 : regs[raddr_a];
    assign rdata_b = (raddr_b == '0) ? '0 : regs[raddr_b];

endmodule

`default_nettype wire

//--- decode/decode_stage.sv
`default_nettype none

module decode_stage (
    input  logic             aclk,
    input  logic             rst,
    input  pipe_pkg::if_id_t if_id,
    input  pipe_pkg::ex_wb_t ex_fwd,   // result forming in execute
    input  pipe_pkg::ex_wb_t wb_fwd,   // entry in write-back, also rf write port
    output pipe_pkg::id_ex_t id_ex
);

    isa_pkg::opcode_t  opcode;
    isa_pkg::funct_t   funct;
    isa_pkg::reg_idx_t rs;
    isa_pkg::reg_idx_t rt;
    isa_pkg::reg_idx_t rd;
    isa_pkg::shamt_t   sa;
    isa_pkg::imm16_t   imm;
    isa_pkg::reg_idx_t src_a;
    isa_pkg::word_t    rdata_a;
    isa_pkg::word_t    rdata_b;
    pipe_pkg::alu_op_t alu_op;
    logic              known;
    logic              use_imm;
    logic              sign_ext;
    logic              is_shift;
    logic              dst_rt;
    pipe_pkg::id_ex_t  id_ex_d;

    assign opcode = isa_pkg::opcode_t'(if_id.instr[31:26]);
    assign funct  = isa_pkg::funct_t'(if_id.instr[5:0]);
    assign rs     = if_id.instr[25:21];
    assign rt     = if_id.instr[20:16];
    assign rd     = if_id.instr[15:11];
    assign sa     = if_id.instr[10:6];
    assign imm    = if_id.instr[15:0];

    // newest producer wins: execute, then write-back, then rf
    function automatic isa_pkg::word_t bypass(input isa_pkg::reg_idx_t idx,
                                              input isa_pkg::word_t rf_val,
                                              input pipe_pkg::ex_wb_t ex_e,
                                              input pipe_pkg::ex_wb_t wb_e);
        if (ex_e.valid && ex_e.reg_wr && ex_e.dst == idx) begin
            return ex_e.result;
        end
        if (wb_e.valid && wb_e.reg_wr && wb_e.dst == idx) begin
            return wb_e.result;
        end
        return rf_val;
    endfunction

    always_comb begin
        alu_op   = pipe_pkg::ALU_ADD;
        known    = 1'b0;
        use_imm  = 1'b0;
        sign_ext = 1'b0;
        is_shift = 1'b0;
        dst_rt   = 1'b1;   // I-type writes rt
        case (opcode)
            isa_pkg::OP_SPECIAL: begin
                dst_rt = 1'b0;
                known  = 1'b1;
                case (funct)
                    isa_pkg::FN_ADDU: alu_op = pipe_pkg::ALU_ADD;
                    isa_pkg::FN_SUBU: alu_op = pipe_pkg::ALU_SUB;
                    isa_pkg::FN_AND:  alu_op = pipe_pkg::ALU_AND;
                    isa_pkg::FN_OR:   alu_op = pipe_pkg::ALU_OR;
                    isa_pkg::FN_XOR:  alu_op = pipe_pkg::ALU_XOR;
                    isa_pkg::FN_SLT:  alu_op = pipe_pkg::ALU_SLT;
                    isa_pkg::FN_SLL: begin
                        alu_op   = pipe_pkg::ALU_SLL;
                        is_shift = 1'b1;
                    end
                    isa_pkg::FN_SRL: begin
                        alu_op   = pipe_pkg::ALU_SRL;
                        is_shift = 1'b1;
                    end
                    default: known = 1'b0;
                endcase
            end
            isa_pkg::OP_ADDIU: begin
                alu_op   = pipe_pkg::ALU_ADD;
                known    = 1'b1;
                use_imm  = 1'b1;
                sign_ext = 1'b1;
            end
            isa_pkg::OP_ANDI: begin
                alu_op  = pipe_pkg::ALU_AND;
                known   = 1'b1;
                use_imm = 1'b1;
            end
            isa_pkg::OP_ORI: begin
                alu_op  = pipe_pkg::ALU_OR;
                known   = 1'b1;
                use_imm = 1'b1;
            end
            isa_pkg::OP_XORI: begin
                alu_op  = pipe_pkg::ALU_XOR;
                known   = 1'b1;
                use_imm = 1'b1;
            end
            isa_pkg::OP_LUI: begin
                alu_op  = pipe_pkg::ALU_LUI;
                known   = 1'b1;
                use_imm = 1'b1;
            end
            default: known = 1'b0;
        endcase
    end

    // shifts take rt as the value to shift
    assign src_a = is_shift ? rt : rs;

    reg_file u_reg_file (
        .aclk    (aclk),
        .rst     (rst),
        .raddr_a (src_a),
        .raddr_b (rt),
        .rdata_a (rdata_a),
        .rdata_b (rdata_b),
        .we      (wb_fwd.valid & wb_fwd.reg_wr),
        .waddr   (wb_fwd.dst),
        .wdata   (wb_fwd.result)
    );

    always_comb begin
        id_ex_d.valid  = if_id.valid;
        id_ex_d.pc     = if_id.pc;
        id_ex_d.alu_op = alu_op;
        id_ex_d.a      = bypass(src_a, rdata_a, ex_fwd, wb_fwd);
        if (is_shift) begin
            id_ex_d.b = isa_pkg::word_t'(sa);
        end else if (use_imm) begin
            id_ex_d.b = sign_ext ? {{16{imm[15]}}, imm} : {16'b0, imm};
        end else begin
            id_ex_d.b = bypass(rt, rdata_b, ex_fwd, wb_fwd);
        end
        id_ex_d.dst    = dst_rt ? rt : rd;
        id_ex_d.reg_wr = known && (id_ex_d.dst != '0);   // r0 writes dropped here
    end

    always_ff @(posedge aclk) begin
        id_ex <= id_ex_d;
        if (rst) begin
            id_ex.valid <= 1'b0;
        end
    end

endmodule

`default_nettype wire

//--- hdl/exe_stage.sv
`default_nettype none

`include "cpu_consts.svh"

module exe_stage (
    input  logic             aclk,
    input  logic             rst,
    input  pipe_pkg::id_ex_t id_ex,
    output pipe_pkg::ex_wb_t ex_res,   // same cycle, feeds decode bypass
    output pipe_pkg::ex_wb_t ex_wb
);

    isa_pkg::word_t  alu_out;
    isa_pkg::shamt_t shamt;
    logic            lt;

    assign shamt = id_ex.b[4:0];
    assign lt    = $signed(id_ex.a) < $signed(id_ex.b);

    always_comb begin
        case (id_ex.alu_op)
            pipe_pkg::ALU_ADD: alu_out = id_ex.a + id_ex.b;   // wraps, no overflow trap
            pipe_pkg::ALU_SUB: alu_out = id_ex.a - id_ex.b;
            pipe_pkg::ALU_AND: alu_out = id_ex.a & id_ex.b;
            pipe_pkg::ALU_OR:  alu_out = id_ex.a | id_ex.b;
            pipe_pkg::ALU_XOR: alu_out = id_ex.a ^ id_ex.b;
            pipe_pkg::ALU_SLT: alu_out = {{(`WORD_W-1){1'b0}}, lt};
            pipe_pkg::ALU_SLL: alu_out = id_ex.a << shamt;
            pipe_pkg::ALU_SRL: alu_out = id_ex.a >> shamt;
            pipe_pkg::ALU_LUI: alu_out = {id_ex.b[15:0], 16'b0};
            default:           alu_out = '0;
        endcase
    end

    always_comb begin
        ex_res.valid  = id_ex.valid;
        ex_res.pc     = id_ex.pc;
        ex_res.result = alu_out;
        ex_res.dst    = id_ex.dst;
        ex_res.reg_wr = id_ex.reg_wr;
    end

    always_ff @(posedge aclk) begin
        ex_wb <= ex_res;
        if (rst) begin
            ex_wb.valid <= 1'b0;
        end
    end

endmodule

`default_nettype wire

//--- hdl/writeback_stage.sv
`default_nettype none

`include "cpu_consts.svh"

module writeback_stage (
    input  pipe_pkg::ex_wb_t        ex_wb,
    output pipe_pkg::ex_wb_t        rf_wb,   // qualified write, to rf and bypass
    output isa_pkg::word_t          debug_wb_pc,
    output isa_pkg::word_t          debug_wb_rf_wdata,
    output logic [`TRACE_WEN_W-1:0] debug_wb_rf_wen,
    output isa_pkg::reg_idx_t       debug_wb_rf_wnum
);

    always_comb begin
        rf_wb        = ex_wb;
        // bubbles never reach the register file
        rf_wb.reg_wr = ex_wb.valid & ex_wb.reg_wr;
    end

    // golden trace
    assign debug_wb_pc       = rf_wb.pc;
    assign debug_wb_rf_wdata = rf_wb.result;
    assign debug_wb_rf_wen   = {`TRACE_WEN_W{rf_wb.reg_wr}};   // all four bytes or none
    assign debug_wb_rf_wnum  = rf_wb.dst;

endmodule

`default_nettype wire

//--- hdl/mycpu_top.sv
`default_nettype none

`include "cpu_consts.svh"

module mycpu_top (
    input  logic                    aclk,
    input  logic                    rst,
    input  logic                    instr_valid,
    input  isa_pkg::word_t          instr,
    output isa_pkg::word_t          debug_wb_pc,
    output isa_pkg::word_t          debug_wb_rf_wdata,
    output logic [`TRACE_WEN_W-1:0] debug_wb_rf_wen,
    output isa_pkg::reg_idx_t       debug_wb_rf_wnum
);

    pipe_pkg::if_id_t if_id;
    pipe_pkg::id_ex_t id_ex;
    pipe_pkg::ex_wb_t ex_res;   // execute result before the EX/WB latch
    pipe_pkg::ex_wb_t ex_wb;
    pipe_pkg::ex_wb_t rf_wb;    // write-back entry after qualification

    fetch_stage u_fetch (
        .aclk        (aclk),
        .rst         (rst),
        .instr_valid (instr_valid),
        .instr       (instr),
        .if_id       (if_id)
    );

    decode_stage u_decode (
        .aclk   (aclk),
        .rst    (rst),
        .if_id  (if_id),
        .ex_fwd (ex_res),
        .wb_fwd (rf_wb),
        .id_ex  (id_ex)
    );

    exe_stage u_exe (
        .aclk   (aclk),
        .rst    (rst),
        .id_ex  (id_ex),
        .ex_res (ex_res),
        .ex_wb  (ex_wb)
    );

    writeback_stage u_wb (
        .ex_wb             (ex_wb),
        .rf_wb             (rf_wb),
        .debug_wb_pc       (debug_wb_pc),
        .debug_wb_rf_wdata (debug_wb_rf_wdata),
        .debug_wb_rf_wen   (debug_wb_rf_wen),
        .debug_wb_rf_wnum  (debug_wb_rf_wnum)
    );

endmodule

`default_nettype wire

//--- verif/mycpu_props.sv
`default_nettype none

`include "cpu_consts.svh"

module mycpu_props (
    input logic                    aclk,
    input logic                    rst,
    input isa_pkg::word_t          debug_wb_pc,
    input logic [`TRACE_WEN_W-1:0] debug_wb_rf_wen,
    input isa_pkg::reg_idx_t       debug_wb_rf_wnum
);

    // trace stays quiet through reset and the cycle after it
    a_wen_in_reset: assert property (@(posedge aclk) rst |=> debug_wb_rf_wen == '0)
        else $error("trace write enable set during or right after reset");

    a_wen_all_or_none: assert property (@(posedge aclk) disable iff (rst)
        debug_wb_rf_wen == '0 || debug_wb_rf_wen == '1)
        else $error("partial trace write enable %h", debug_wb_rf_wen);

    a_wnum_nonzero: assert property (@(posedge aclk) disable iff (rst)
        debug_wb_rf_wen != '0 |-> debug_wb_rf_wnum != '0)
        else $error("trace write to register 0");

    a_pc_aligned: assert property (@(posedge aclk) disable iff (rst)
        debug_wb_rf_wen != '0 |-> debug_wb_pc[1:0] == 2'b00)
        else $error("unaligned trace pc %h", debug_wb_pc);

endmodule

bind mycpu_top mycpu_props u_props (
    .aclk             (aclk),
    .rst              (rst),
    .debug_wb_pc      (debug_wb_pc),
    .debug_wb_rf_wen  (debug_wb_rf_wen),
    .debug_wb_rf_wnum (debug_wb_rf_wnum)
);

`default_nettype wire

//--- verif/tb_mycpu.sv
`default_nettype none

`include "cpu_consts.svh"

module tb_mycpu;

    // one table row, stimulus plus the write it should cause
    typedef struct packed {
        logic              valid;
        isa_pkg::word_t    instr;
        logic              wr;
        isa_pkg::word_t    pc;
        isa_pkg::word_t    data;
        isa_pkg::reg_idx_t dst;
    } step_t;

    typedef struct packed {
        isa_pkg::word_t    pc;
        isa_pkg::word_t    data;
        isa_pkg::reg_idx_t dst;
    } trace_t;

    logic                    aclk;
    logic                    rst;
    logic                    instr_valid;
    isa_pkg::word_t          instr;
    isa_pkg::word_t          debug_wb_pc;
    isa_pkg::word_t          debug_wb_rf_wdata;
    logic [`TRACE_WEN_W-1:0] debug_wb_rf_wen;
    isa_pkg::reg_idx_t       debug_wb_rf_wnum;

    step_t          steps[$];
    trace_t         expq[$];              // writes still to appear on the trace
    isa_pkg::word_t mregs [`REG_NUM];     // reference register file
    isa_pkg::word_t mpc;
    logic [31:0]    rand_state;
    logic           table_ready;

    mycpu_top DUT (
        .aclk              (aclk),
        .rst               (rst),
        .instr_valid       (instr_valid),
        .instr             (instr),
        .debug_wb_pc       (debug_wb_pc),
        .debug_wb_rf_wdata (debug_wb_rf_wdata),
        .debug_wb_rf_wen   (debug_wb_rf_wen),
        .debug_wb_rf_wnum  (debug_wb_rf_wnum)
    );

    initial begin
        aclk = 1'b0;
        forever #2 aclk = ~aclk;
    end

    function automatic logic [31:0] next_rand(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    function automatic isa_pkg::word_t r_type(input isa_pkg::funct_t fn, input int rs,
                                              input int rt, input int rd, input int sa);
        return {6'h00, 5'(rs), 5'(rt), 5'(rd), 5'(sa), fn};
    endfunction

    function automatic isa_pkg::word_t i_type(input isa_pkg::opcode_t op, input int rs,
                                              input int rt, input logic [15:0] imm);
        return {op, 5'(rs), 5'(rt), imm};
    endfunction

    // MIPS32 semantics from the raw encoding
    task automatic model_exec(input isa_pkg::word_t ins, output logic wr,
                              output isa_pkg::word_t res, output isa_pkg::reg_idx_t dst);
        logic [5:0]     op;
        logic [5:0]     fn;
        isa_pkg::word_t va;
        isa_pkg::word_t vb;
        logic           known;
        op    = ins[31:26];
        fn    = ins[5:0];
        va    = mregs[ins[25:21]];
        vb    = mregs[ins[20:16]];
        known = 1'b1;
        res   = '0;
        dst   = ins[20:16];
        if (op == 6'h00) begin
            dst = ins[15:11];
            case (fn)
                6'h21:   res = va + vb;
                6'h23:   res = va - vb;
                6'h24:   res = va & vb;
                6'h25:   res = va | vb;
                6'h26:   res = va ^ vb;
                6'h2a:   res = ($signed(va) < $signed(vb)) ? 32'd1 : 32'd0;
                6'h00:   res = vb << ins[10:6];
                6'h02:   res = vb >> ins[10:6];
                default: known = 1'b0;
            endcase
        end else begin
            case (op)
                6'h09:   res = va + {{16{ins[15]}}, ins[15:0]};   // sign extended
                6'h0c:   res = va & {16'h0000, ins[15:0]};
                6'h0d:   res = va | {16'h0000, ins[15:0]};
                6'h0e:   res = va ^ {16'h0000, ins[15:0]};
                6'h0f:   res = {ins[15:0], 16'h0000};
                default: known = 1'b0;
            endcase
        end
        wr = known && (dst != 5'd0);
    endtask

    task automatic add_entry(input logic valid, input isa_pkg::word_t ins);
        step_t             s;
        logic              wr;
        isa_pkg::word_t    res;
        isa_pkg::reg_idx_t dst;
        s       = '0;
        s.valid = valid;
        s.instr = ins;
        if (valid) begin
            model_exec(ins, wr, res, dst);
            s.wr   = wr;
            s.pc   = mpc;
            s.data = res;
            s.dst  = dst;
            if (wr) begin
                mregs[dst] = res;
            end
            mpc = mpc + 32'd4;   // pc only moves on accepted instructions
        end
        steps.push_back(s);
    endtask

    task automatic add_instr(input isa_pkg::word_t ins);
        add_entry(1'b1, ins);
    endtask

    task automatic add_bubbles(input int n);
        repeat (n) add_entry(1'b0, 32'h0);
    endtask

    task automatic build_table();
        int             src;
        int             dst_r;
        isa_pkg::word_t ins;
        mpc = `RESET_PC;
        for (int i = 0; i < `REG_NUM; i++) begin
            mregs[i] = '0;
        end
        // every ALU op, ORI right after LUI is a distance 1 bypass
        add_instr(i_type(isa_pkg::OP_ADDIU, 0, 1, 16'h1234));
        add_instr(i_type(isa_pkg::OP_ADDIU, 0, 2, 16'hfffb));   // -5
        add_instr(i_type(isa_pkg::OP_LUI, 0, 3, 16'h8765));
        add_instr(i_type(isa_pkg::OP_ORI, 3, 3, 16'h4321));
        add_instr(r_type(isa_pkg::FN_ADDU, 1, 2, 4, 0));
        add_instr(r_type(isa_pkg::FN_SUBU, 4, 1, 5, 0));
        add_instr(r_type(isa_pkg::FN_AND, 3, 1, 6, 0));
        add_instr(r_type(isa_pkg::FN_OR, 3, 2, 7, 0));
        add_instr(r_type(isa_pkg::FN_XOR, 7, 6, 8, 0));
        add_instr(r_type(isa_pkg::FN_SLT, 2, 1, 9, 0));    // negative vs positive
        add_instr(r_type(isa_pkg::FN_SLT, 1, 2, 10, 0));
        add_instr(r_type(isa_pkg::FN_SLT, 3, 2, 11, 0));   // both negative
        add_instr(r_type(isa_pkg::FN_SLL, 0, 1, 12, 4));
        add_instr(r_type(isa_pkg::FN_SRL, 0, 3, 13, 8));
        add_instr(i_type(isa_pkg::OP_ANDI, 2, 14, 16'hf0f0));
        add_instr(i_type(isa_pkg::OP_XORI, 2, 15, 16'h00ff));
        add_instr(r_type(isa_pkg::FN_SRL, 0, 2, 31, 31));
        add_bubbles(3);
        // no trace write expected for these
        add_instr(i_type(isa_pkg::OP_ADDIU, 1, 0, 16'h0007));
        add_instr(r_type(isa_pkg::FN_ADDU, 1, 1, 0, 0));
        add_instr(32'h8c25_0000);   // lw r5, 0(r1)
        add_instr(32'h0022_3818);   // mult r1, r2 with rd = 7
        add_instr(r_type(isa_pkg::FN_ADDU, 0, 1, 16, 0));
        add_instr(r_type(isa_pkg::FN_OR, 0, 0, 17, 0));
        add_instr(r_type(isa_pkg::FN_SUBU, 5, 7, 18, 0));
        // distance 1, 2 and 3 dependences, some across bubbles
        add_instr(i_type(isa_pkg::OP_ADDIU, 0, 19, 16'h0001));
        add_instr(r_type(isa_pkg::FN_ADDU, 19, 19, 20, 0));
        add_instr(r_type(isa_pkg::FN_ADDU, 20, 19, 21, 0));
        add_instr(r_type(isa_pkg::FN_SUBU, 21, 19, 22, 0));
        add_bubbles(1);
        add_instr(r_type(isa_pkg::FN_XOR, 22, 21, 22, 0));
        add_bubbles(2);
        add_instr(r_type(isa_pkg::FN_SLL, 0, 22, 22, 3));
        add_instr(r_type(isa_pkg::FN_SLT, 22, 20, 23, 0));
        // long chain with random immediates, each reads the last result
        rand_state = 32'h281c;
        src        = 22;
        for (int i = 0; i < 48; i++) begin
            rand_state = next_rand(rand_state);
            dst_r      = 23 + int'(rand_state[11:10]);
            case (rand_state[13:12])
                2'd0:    ins = i_type(isa_pkg::OP_ADDIU, src, dst_r, rand_state[31:16]);
                2'd1:    ins = i_type(isa_pkg::OP_ORI, src, dst_r, rand_state[31:16]);
                default: ins = i_type(isa_pkg::OP_XORI, src, dst_r, rand_state[31:16]);
            endcase
            add_instr(ins);
            if (rand_state[15:14] == 2'd0) begin
                add_bubbles(1);
            end
            src = dst_r;
        end
        add_instr(r_type(isa_pkg::FN_ADDU, 23, 24, 27, 0));
        add_instr(r_type(isa_pkg::FN_SUBU, 25, 26, 28, 0));
        add_instr(r_type(isa_pkg::FN_XOR, 27, 28, 29, 0));
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("error: %s is %h, expected %h", name, got, exp);
            $display("TEST FAILED");
            $fatal(1, "stopping at the first mismatch");
        end
    endtask

    task automatic check_trace();
        trace_t t;
        if (debug_wb_rf_wen != '0) begin
            if (expq.size() == 0) begin
                $display("register write to r%0d at pc %h that the model does not expect",
                         debug_wb_rf_wnum, debug_wb_pc);
                $display("TEST FAILED");
                $fatal(1, "unexpected trace write");
            end else begin
                t = expq.pop_front();
                check_value("debug_wb_rf_wen", 32'(debug_wb_rf_wen), 32'h0000_000f);
                check_value("debug_wb_pc", debug_wb_pc, t.pc);
                check_value("debug_wb_rf_wdata", debug_wb_rf_wdata, t.data);
                check_value("debug_wb_rf_wnum", 32'(debug_wb_rf_wnum), 32'(t.dst));
            end
        end
    endtask

    // outputs are checked on the falling edge before new inputs go out
    task automatic run_cycle(input step_t s);
        @(negedge aclk);
        check_trace();
        instr_valid = s.valid;
        instr       = s.instr;
        if (s.wr) begin
            expq.push_back('{pc: s.pc, data: s.data, dst: s.dst});
        end
    endtask

    initial begin
        wait (table_ready);
        #((steps.size() + 20) * 4);
        $display("timeout: trace writes did not finish within %0d cycles", steps.size() + 20);
        $display("TEST FAILED");
        $fatal(1, "watchdog expired");
    end

    initial begin
        rst         = 1'b1;
        instr_valid = 1'b0;
        instr       = '0;
        table_ready = 1'b0;
        build_table();
        table_ready = 1'b1;
        repeat (2) @(posedge aclk);
        @(negedge aclk);
        rst = 1'b0;
        foreach (steps[i]) begin
            run_cycle(steps[i]);
        end
        // last write shows 3 cycles after its edge, the rest catch stray writes
        repeat (6) run_cycle('0);
        if (expq.size() != 0) begin
            $display("%0d expected trace writes never appeared", expq.size());
            $display("TEST FAILED");
            $fatal(1, "missing trace writes");
        end else begin
            $display("TEST PASSED");
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- files.f
+incdir+common
common/isa_pkg.sv
common/pipe_pkg.sv
hdl/fetch_stage.sv
decode/reg_file.sv
decode/decode_stage.sv
hdl/exe_stage.sv
hdl/writeback_stage.sv
hdl/mycpu_top.sv
verif/mycpu_props.sv
verif/tb_mycpu.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_mycpu
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert -j 0
PASS_MSG  ?= TEST PASSED

SRCS := $(shell grep -v '^+' $(FILELIST)) common/cpu_consts.svh

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "^$(PASS_MSG)$$" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
